//--- include/edge_write_consts.svh
// Sizes for the edge-data write path; buffer depth must stay a power of two
`ifndef EDGE_WRITE_CONSTS_SVH
`define EDGE_WRITE_CONSTS_SVH

////////////////////////////////////////////////////////////
// Line and word geometry
////////////////////////////////////////////////////////////

// Cache line in bytes
`define EW_LINE_BYTES 64
// Result word in bytes
`define EW_WORD_BYTES 4
// Words per cache line
`define EW_SLOTS 16

////////////////////////////////////////////////////////////
// Field widths
////////////////////////////////////////////////////////////

`define EW_ADDR_W 48
`define EW_INDEX_W 32
`define EW_CU_ID_W 8
`define EW_CONFIG_W 32
// Ordering field sits at config bits 17 down to 15
`define EW_ABT_LSB 15
`define EW_ABT_W 3

// Write line queue entries
`define EW_BUFFER_DEPTH 8

`endif

//--- design/edge_write_pkg.sv
// Types and helpers for the edge-data write path; one fixed configuration, no parameters
package edge_write_pkg;

	`include "edge_write_consts.svh"

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	// Byte address into the output array
	typedef logic [`EW_ADDR_W-1:0] addr_t;
	// Vertex index reported by the compute unit
	typedef logic [`EW_INDEX_W-1:0] index_t;
	// One result word
	typedef logic [`EW_WORD_BYTES*8-1:0] word_t;
	// Full cache line of data
	typedef logic [`EW_LINE_BYTES*8-1:0] line_t;
	// One enable per byte of the line
	typedef logic [`EW_LINE_BYTES-1:0] byte_en_t;
	// Word position inside the line
	typedef logic [$clog2(`EW_SLOTS)-1:0] slot_t;
	typedef logic [`EW_CU_ID_W-1:0] cu_id_t;
	typedef logic [`EW_CONFIG_W-1:0] config_t;

	// Translation ordering modes
	typedef enum logic [`EW_ABT_W-1:0] {
		STRICT = 3'd0,
		ABORT  = 3'd1,
		PAGE   = 3'd2,
		PREF   = 3'd3,
		SPEC   = 3'd4
	} abt_t;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Reserved codes 5 to 7 fall back to strict ordering
	function automatic abt_t map_abt(input logic [`EW_ABT_W-1:0] field);
		case (field)
			3'd1: return ABORT;
			3'd2: return PAGE;
			3'd3: return PREF;
			3'd4: return SPEC;
			default: return STRICT;
		endcase
	endfunction

	// Byte order reversal, host to memory endianness
	function automatic word_t swap_bytes(input word_t w);
		word_t r;
		for (int i = 0; i < `EW_WORD_BYTES; i++) begin
			r[i*8 +: 8] = w[(`EW_WORD_BYTES-1-i)*8 +: 8];
		end
		return r;
	endfunction

endpackage

//--- design/write_line_if.sv
// One finished write line per valid strobe; no acknowledge, fields valid only with the strobe
`timescale 1ns/10ps

interface write_line_if import edge_write_pkg::*; ();

	// Single-cycle strobe per line
	logic     valid;
	addr_t    address;
	cu_id_t   cu_id;
	abt_t     abt;
	slot_t    slot;
	line_t    data;
	byte_en_t byte_enable;

	// Control block side
	modport source (
		output valid, address, cu_id, abt, slot, data, byte_enable
	);

	// Queue side
	modport sink (
		input valid, address, cu_id, abt, slot, data, byte_enable
	);

endinterface

//--- design/edge_data_write_control.sv
// Builds one line per enabled write strobe, two cycles later; requests while disabled are dropped
`timescale 1ns/10ps
`include "edge_write_consts.svh"

module edge_data_write_control import edge_write_pkg::*; (
	input  logic   clock,
	input  logic   rstn,
	input  logic   enabled_in,
	input  config_t cu_configure,
	input  addr_t  wed_base,
	input  logic   write_valid,
	input  index_t write_index,
	input  word_t  write_data,
	input  cu_id_t write_cu_id,
	write_line_if.source line_out
);

	logic    enabled;
	addr_t   base_q;
	config_t config_q;

	// Combinational line fields from the current request
	slot_t    slot_c;
	addr_t    address_c;
	line_t    data_c;
	byte_en_t byte_en_c;
	abt_t     abt_c;

	// Build stage
	logic     build_valid;
	addr_t    build_address;
	cu_id_t   build_cu_id;
	abt_t     build_abt;
	slot_t    build_slot;
	line_t    build_data;
	byte_en_t build_byte_en;

	////////////////////////////////////////////////////////////
	// Enable and captured settings
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled  <= 1'b0;
			base_q   <= '0;
			config_q <= '0;
		end else begin
			// One cycle delay on the enable
			enabled <= enabled_in;
			if (enabled) begin
				base_q <= wed_base;
				// Zero config word means keep the old one
				if (|cu_configure)
					config_q <= cu_configure;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Line field computation
	////////////////////////////////////////////////////////////

	always_comb begin
		// Low index bits pick the word in the line
		slot_c    = write_index[$bits(slot_t)-1:0];
		address_c = base_q + (addr_t'(write_index) << $clog2(`EW_WORD_BYTES));
		// Swapped word placed in its slot, rest of line zero
		data_c    = line_t'(swap_bytes(write_data)) << (slot_c * `EW_WORD_BYTES * 8);
		byte_en_c = byte_en_t'({`EW_WORD_BYTES{1'b1}}) << (slot_c * `EW_WORD_BYTES);
		abt_c     = map_abt(config_q[`EW_ABT_LSB +: `EW_ABT_W]);
	end

	// Stage one, zero unless an enabled request is present
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			build_valid   <= 1'b0;
			build_address <= '0;
			build_cu_id   <= '0;
			build_abt     <= STRICT;
			build_slot    <= '0;
			build_data    <= '0;
			build_byte_en <= '0;
		end else if (write_valid && enabled) begin
			build_valid   <= 1'b1;
			build_address <= address_c;
			build_cu_id   <= write_cu_id;
			build_abt     <= abt_c;
			build_slot    <= slot_c;
			build_data    <= data_c;
			build_byte_en <= byte_en_c;
		end else begin
			build_valid   <= 1'b0;
			build_address <= '0;
			build_cu_id   <= '0;
			build_abt     <= STRICT;
			build_slot    <= '0;
			build_data    <= '0;
			build_byte_en <= '0;
		end
	end

	////////////////////////////////////////////////////////////
	// Output stage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			line_out.valid       <= 1'b0;
			line_out.address     <= '0;
			line_out.cu_id       <= '0;
			line_out.abt         <= STRICT;
			line_out.slot        <= '0;
			line_out.data        <= '0;
			line_out.byte_enable <= '0;
		end else if (build_valid && enabled) begin
			line_out.valid       <= 1'b1;
			line_out.address     <= build_address;
			line_out.cu_id       <= build_cu_id;
			line_out.abt         <= build_abt;
			line_out.slot        <= build_slot;
			line_out.data        <= build_data;
			line_out.byte_enable <= build_byte_en;
		end else begin
			// Strobe drops after one cycle
			line_out.valid       <= 1'b0;
			line_out.address     <= '0;
			line_out.cu_id       <= '0;
			line_out.abt         <= STRICT;
			line_out.slot        <= '0;
			line_out.data        <= '0;
			line_out.byte_enable <= '0;
		end
	end

endmodule

//--- design/write_line_buffer.sv
// Write line FIFO, power-of-two depth; no back-pressure, a push while full is lost and flagged
`timescale 1ns/10ps
`include "edge_write_consts.svh"

module write_line_buffer import edge_write_pkg::*; (
	input  logic     clock,
	input  logic     rstn,
	write_line_if.sink line_in,
	input  logic     mem_grant,
	output logic     mem_valid,
	output addr_t    mem_address,
	output cu_id_t   mem_cu_id,
	output abt_t     mem_abt,
	output slot_t    mem_slot,
	output line_t    mem_data,
	output byte_en_t mem_byte_enable,
	output logic     overflow
);

	// Entry storage, one array per field
	addr_t    address_mem [`EW_BUFFER_DEPTH];
	cu_id_t   cu_id_mem   [`EW_BUFFER_DEPTH];
	abt_t     abt_mem     [`EW_BUFFER_DEPTH];
	slot_t    slot_mem    [`EW_BUFFER_DEPTH];
	line_t    data_mem    [`EW_BUFFER_DEPTH];
	byte_en_t byte_en_mem [`EW_BUFFER_DEPTH];

	// Pointers wrap on their own
	logic [$clog2(`EW_BUFFER_DEPTH)-1:0] wr_ptr;
	logic [$clog2(`EW_BUFFER_DEPTH)-1:0] rd_ptr;
	logic [$clog2(`EW_BUFFER_DEPTH+1)-1:0] count;

	logic full;
	logic empty;
	logic push;
	logic pop;

	////////////////////////////////////////////////////////////
	// Queue state
	////////////////////////////////////////////////////////////

	assign full  = (count == `EW_BUFFER_DEPTH);
	assign empty = (count == '0);
	// Full check ignores a pop in the same cycle
	assign push  = line_in.valid && !full;
	// Grant on an empty queue is ignored
	assign pop   = mem_grant && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Both at once leave count unchanged
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// Sticky until reset
			if (line_in.valid && full)
				overflow <= 1'b1;
		end
	end

	// Entry write
	always_ff @(posedge clock) begin
		if (push) begin
			address_mem[wr_ptr] <= line_in.address;
			cu_id_mem[wr_ptr]   <= line_in.cu_id;
			abt_mem[wr_ptr]     <= line_in.abt;
			slot_mem[wr_ptr]    <= line_in.slot;
			data_mem[wr_ptr]    <= line_in.data;
			byte_en_mem[wr_ptr] <= line_in.byte_enable;
		end
	end

	////////////////////////////////////////////////////////////
	// Head presentation
	////////////////////////////////////////////////////////////

	assign mem_valid       = !empty;
	assign mem_address     = address_mem[rd_ptr];
	assign mem_cu_id       = cu_id_mem[rd_ptr];
	assign mem_abt         = abt_mem[rd_ptr];
	assign mem_slot        = slot_mem[rd_ptr];
	assign mem_data        = data_mem[rd_ptr];
	assign mem_byte_enable = byte_en_mem[rd_ptr];

endmodule

//--- design/edge_write_unit.sv
// Write path top; mem_* fields are meaningful only while mem_valid is high
`timescale 1ns/10ps

module edge_write_unit import edge_write_pkg::*; (
	input  logic     clock,
	input  logic     rstn,
	input  logic     enabled_in,
	input  config_t  cu_configure,
	input  addr_t    wed_base,
	input  logic     write_valid,
	input  index_t   write_index,
	input  word_t    write_data,
	input  cu_id_t   write_cu_id,
	input  logic     mem_grant,
	output logic     mem_valid,
	output addr_t    mem_address,
	output cu_id_t   mem_cu_id,
	output abt_t     mem_abt,
	output slot_t    mem_slot,
	output line_t    mem_data,
	output byte_en_t mem_byte_enable,
	output logic     overflow
);

	// Control to queue link
	write_line_if line_if ();

	// Line builder
	edge_data_write_control i_edge_data_write_control (
		.clock        (clock),
		.rstn         (rstn),
		.enabled_in   (enabled_in),
		.cu_configure (cu_configure),
		.wed_base     (wed_base),
		.write_valid  (write_valid),
		.write_index  (write_index),
		.write_data   (write_data),
		.write_cu_id  (write_cu_id),
		.line_out     (line_if.source)
	);

	// Holds lines until the arbiter grants them
	write_line_buffer i_write_line_buffer (
		.clock           (clock),
		.rstn            (rstn),
		.line_in         (line_if.sink),
		.mem_grant       (mem_grant),
		.mem_valid       (mem_valid),
		.mem_address     (mem_address),
		.mem_cu_id       (mem_cu_id),
		.mem_abt         (mem_abt),
		.mem_slot        (mem_slot),
		.mem_data        (mem_data),
		.mem_byte_enable (mem_byte_enable),
		.overflow        (overflow)
	);

endmodule

//--- testbench/edge_write_unit_chk.sv
// Bound into edge_write_unit; rd_ptr is taken from the queue instance inside the DUT
`timescale 1ns/10ps
`include "edge_write_consts.svh"

module edge_write_unit_chk (
	input logic                                clock,
	input logic                                rstn,
	input logic                                mem_valid,
	input logic                                mem_grant,
	input logic [$clog2(`EW_SLOTS)-1:0]        mem_slot,
	input logic [`EW_LINE_BYTES-1:0]           mem_byte_enable,
	input logic                                overflow,
	input logic [$clog2(`EW_BUFFER_DEPTH)-1:0] rd_ptr
);

	// Assertion failures so far
	int unsigned error_count = 0;

	// Sticky flag cleared only by reset
	overflow_sticky: assert property (@(posedge clock) disable iff (!rstn)
		$past(overflow) |-> overflow)
		else begin
			error_count++;
			$error("overflow fell without reset");
		end

	// One word per line
	byte_enable_count: assert property (@(posedge clock) disable iff (!rstn)
		mem_valid |-> $countones(mem_byte_enable) == `EW_WORD_BYTES)
		else begin
			error_count++;
			$error("mem_byte_enable does not hold exactly one word");
		end

	byte_enable_slot: assert property (@(posedge clock) disable iff (!rstn)
		mem_valid |-> mem_byte_enable == ({`EW_LINE_BYTES{1'b0}} | 4'hf) << (mem_slot * 4))
		else begin
			error_count++;
			$error("mem_byte_enable does not match mem_slot");
		end

	// Grant on an empty queue leaves the head where it is
	no_empty_pop: assert property (@(posedge clock) disable iff (!rstn)
		(mem_grant && !mem_valid) |=> rd_ptr == $past(rd_ptr))
		else begin
			error_count++;
			$error("grant popped an empty queue");
		end

endmodule

//--- testbench/edge_write_unit_tb.sv
// Run from the project root; cfg records hold their values until the next cfg record
`timescale 1ns/10ps
`include "edge_write_consts.svh"

module edge_write_unit_tb;

	localparam int CLOCK_PERIOD = 40;

	// Expected line as it enters the queue
	typedef struct packed {
		logic [`EW_ADDR_W-1:0]        address;
		logic [`EW_CU_ID_W-1:0]       cu_id;
		logic [`EW_ABT_W-1:0]         abt;
		logic [$clog2(`EW_SLOTS)-1:0] slot;
		logic [`EW_LINE_BYTES*8-1:0]  data;
		logic [`EW_LINE_BYTES-1:0]    byte_enable;
	} line_rec_t;

	logic clock;
	logic rstn;
	logic enabled_in;
	logic [`EW_CONFIG_W-1:0] cu_configure;
	logic [`EW_ADDR_W-1:0] wed_base;
	logic write_valid;
	logic [`EW_INDEX_W-1:0] write_index;
	logic [`EW_WORD_BYTES*8-1:0] write_data;
	logic [`EW_CU_ID_W-1:0] write_cu_id;
	logic mem_grant;
	logic mem_valid;
	logic [`EW_ADDR_W-1:0] mem_address;
	logic [`EW_CU_ID_W-1:0] mem_cu_id;
	logic [`EW_ABT_W-1:0] mem_abt;
	logic [$clog2(`EW_SLOTS)-1:0] mem_slot;
	logic [`EW_LINE_BYTES*8-1:0] mem_data;
	logic [`EW_LINE_BYTES-1:0] mem_byte_enable;
	logic overflow;

	// Reference model state
	line_rec_t model_q[$];
	line_rec_t build_line;
	line_rec_t out_line;
	logic build_ok;
	logic out_ok;
	logic m_enabled;
	logic [`EW_ADDR_W-1:0] m_base;
	logic [`EW_CONFIG_W-1:0] m_config;

	// Values from the latest cfg record
	logic hold_enable;
	logic [`EW_CONFIG_W-1:0] hold_config;
	logic [`EW_ADDR_W-1:0] hold_base;

	string records[$];
	int record_count = 0;
	int cur_test;
	int test_errors;
	int tests_passed = 0;
	int tests_failed = 0;
	// Checker failures already charged to a test
	int chk_seen = 0;
	logic file_ok;

	edge_write_unit i_edge_write_unit (.*);

	bind edge_write_unit edge_write_unit_chk i_edge_write_unit_chk (
		.clock           (clock),
		.rstn            (rstn),
		.mem_valid       (mem_valid),
		.mem_grant       (mem_grant),
		.mem_slot        (mem_slot),
		.mem_byte_enable (mem_byte_enable),
		.overflow        (overflow),
		.rd_ptr          (i_write_line_buffer.rd_ptr)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Expected line from base, config and request
	function automatic line_rec_t expected_line(input logic [`EW_ADDR_W-1:0] base,
		input logic [`EW_CONFIG_W-1:0] cfg, input logic [31:0] index,
		input logic [31:0] word, input logic [7:0] id);
		line_rec_t l;
		logic [2:0] field;
		l = '0;
		l.slot = index % `EW_SLOTS;
		l.address = base + index * 48'd4;
		// Byte-reversed word in its slot
		l.data[l.slot*32 +: 32] = {word[7:0], word[15:8], word[23:16], word[31:24]};
		l.byte_enable[l.slot*4 +: 4] = 4'hf;
		field = cfg[`EW_ABT_LSB +: 3];
		// Reserved codes read as strict
		l.abt = (field > 3'd4) ? 3'd0 : field;
		l.cu_id = id;
		return l;
	endfunction

	// Inputs are stable at the rising edge since they change on the falling one
	always @(posedge clock) begin : model_step
		int depth_before;
		if (!rstn) begin
			model_q.delete();
			m_enabled = 1'b0;
			m_base = '0;
			m_config = '0;
			build_ok = 1'b0;
			out_ok = 1'b0;
		end else begin
			// Room is judged before this edge's pop
			depth_before = model_q.size();
			if (mem_grant && depth_before != 0)
				void'(model_q.pop_front());
			if (out_ok && depth_before < `EW_BUFFER_DEPTH)
				model_q.push_back(out_line);
			out_ok = build_ok && m_enabled;
			out_line = build_line;
			build_ok = write_valid && m_enabled;
			build_line = expected_line(m_base, m_config, write_index, write_data, write_cu_id);
			if (m_enabled) begin
				m_base = wed_base;
				if (cu_configure != '0)
					m_config = cu_configure;
			end
			m_enabled = enabled_in;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks and stimulus
	////////////////////////////////////////////////////////////

	task automatic check_field(input string name, input logic [`EW_LINE_BYTES*8-1:0] got,
		input logic [`EW_LINE_BYTES*8-1:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] test %0d: %s is %0h, expected %0h", cur_test, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic compare_head(input line_rec_t exp);
		check_field("mem_address", mem_address, exp.address);
		check_field("mem_cu_id", mem_cu_id, exp.cu_id);
		check_field("mem_abt", mem_abt, exp.abt);
		check_field("mem_slot", mem_slot, exp.slot);
		check_field("mem_data", mem_data, exp.data);
		check_field("mem_byte_enable", mem_byte_enable, exp.byte_enable);
	endtask

	// One clock cycle checked and driven at the falling edge
	task automatic run_cycle(input logic wv, input logic [31:0] idx, input logic [31:0] word,
		input logic [7:0] id, input logic gnt);
		@(negedge clock);
		check_field("mem_valid", mem_valid, model_q.size() != 0);
		// The head seen now is what this grant pops
		if (gnt && model_q.size() != 0)
			compare_head(model_q[0]);
		enabled_in = hold_enable;
		cu_configure = hold_config;
		wed_base = hold_base;
		write_valid = wv;
		write_index = idx;
		write_data = word;
		write_cu_id = id;
		mem_grant = gnt;
	endtask

	task automatic close_test();
		int chk_now;
		chk_now = i_edge_write_unit.i_edge_write_unit_chk.error_count;
		if (test_errors == 0 && chk_now == chk_seen) begin
			$display("test %0d: ok", cur_test);
			tests_passed++;
		end else begin
			$display("test %0d: %0d errors", cur_test, test_errors + chk_now - chk_seen);
			tests_failed++;
		end
		chk_seen = chk_now;
	endtask

	task automatic load_records(output logic ok);
		int fd;
		string line;
		fd = $fopen("testbench/edge_write_tests.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while ($fgets(line, fd) != 0) begin
				// Comments and blank lines skipped
				if (line.len() > 1 && line.getc(0) != "#")
					records.push_back(line);
			end
			$fclose(fd);
			record_count = records.size();
		end
	endtask

	task automatic run_records();
		string op;
		int n;
		int test;
		logic [63:0] f1;
		logic [63:0] f2;
		logic [63:0] f3;
		logic [63:0] f4;
		cur_test = -1;
		test_errors = 0;
		foreach (records[i]) begin
			n = $sscanf(records[i], "%d %s %h %h %h %h", test, op, f1, f2, f3, f4);
			if (test != cur_test) begin
				if (cur_test >= 0)
					close_test();
				cur_test = test;
				test_errors = 0;
			end
			case (op)
				"cfg": begin
					hold_config = f1[31:0];
					hold_base = f2[47:0];
					hold_enable = f3[0];
				end
				"wr": run_cycle(1'b1, f1[31:0], f2[31:0], f3[7:0], (n == 6) && f4[0]);
				"grant": run_cycle(1'b0, '0, '0, '0, 1'b1);
				"idle": repeat (f1) run_cycle(1'b0, '0, '0, '0, 1'b0);
				"expect_overflow": check_field("overflow", overflow, f1[0]);
				default: begin
					$display("test %0d: unknown operation %s in stimulus file", test, op);
					test_errors++;
				end
			endcase
		end
		if (cur_test >= 0)
			close_test();
	endtask

	initial begin
		rstn = 1'b0;
		enabled_in = 1'b0;
		cu_configure = '0;
		wed_base = '0;
		write_valid = 1'b0;
		write_index = '0;
		write_data = '0;
		write_cu_id = '0;
		mem_grant = 1'b0;
		hold_enable = 1'b0;
		hold_config = '0;
		hold_base = '0;
		load_records(file_ok);
		repeat (5) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		if (!file_ok || record_count == 0) begin
			$display("Stimulus file missing or empty, nothing was run");
			$display("TESTS FAILED");
		end else begin
			run_records();
			$display("Summary: %0d passing tests, %0d failing tests", tests_passed, tests_failed);
			if (tests_failed == 0)
				$display("TESTS PASSED");
			else
				$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog allows 40 cycles per record
	initial begin
		wait (record_count > 0);
		#(record_count * 40 * CLOCK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", record_count * 40);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- edge_write_unit.f
+incdir+include
design/edge_write_pkg.sv
design/write_line_if.sv
design/edge_data_write_control.sv
design/write_line_buffer.sv
design/edge_write_unit.sv
testbench/edge_write_unit_chk.sv
testbench/edge_write_unit_tb.sv

//--- Bender.yml
package:
  name: edge_write_unit

sources:
  - include_dirs:
      - include
    files:
      - design/edge_write_pkg.sv
      - design/write_line_if.sv
      - design/edge_data_write_control.sv
      - design/write_line_buffer.sv
      - design/edge_write_unit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/edge_write_unit_chk.sv
      - testbench/edge_write_unit_tb.sv

//--- testbench/edge_write_tests.txt
# test op fields in hex: cfg config base enable | wr index data cu_id [grant]
# grant | idle cycles | expect_overflow flag; cfg values apply from the next cycle
1 cfg 00010000 000000100000 1
1 idle 3
1 wr 00000005 11223344 07
1 idle 3
1 grant
2 wr 00000000 a1b2c3d4 01
2 wr 0000000f 0badf00d 02
2 wr 00000010 cafef00d 03
2 wr 0000001f 12345678 04 1
2 idle 1
2 grant
2 grant
2 grant
3 cfg 00000001 000000200000 1
3 wr 00000003 00000010 10 1
3 cfg 00008001 000000200000 1
3 wr 00000013 00000011 11 1
3 cfg 00010001 000000200000 1
3 wr 00000023 00000012 12 1
3 cfg 00018001 000000200000 1
3 wr 00000033 00000013 13 1
3 cfg 00028001 000000200000 1
3 wr 00000043 00000014 14 1
3 cfg 00030001 000000200000 1
3 wr 00000053 00000015 15 1
3 cfg 00038001 000000200000 1
3 wr 00000063 00000016 16 1
3 cfg 00020001 000000200000 1
3 wr 00000073 00000017 17 1
3 cfg 00000000 000000200000 1
3 wr 00000083 00000018 18 1
3 wr 00000093 00000019 19 1
3 idle 2
3 grant
3 grant
3 grant
4 cfg 00020000 000000300000 0
4 idle 2
4 wr 00000001 deadbeef 20
4 cfg 00020000 000000300000 1
4 wr 00000002 deadbeef 21
4 wr 00000003 feedface 22
4 idle 3
4 grant
4 expect_overflow 0
5 wr 00000040 00000100 30
5 wr 00000041 00000101 31
5 wr 00000042 00000102 32
5 wr 00000043 00000103 33
5 wr 00000044 00000104 34
5 wr 00000045 00000105 35
5 wr 00000046 00000106 36
5 wr 00000047 00000107 37
5 wr 00000048 00000108 38
5 idle 3
5 expect_overflow 1
6 grant
6 wr 00000050 00000200 40 1
6 wr 00000051 00000201 41 1
6 wr 00000052 00000202 42 1
6 grant
6 grant
6 grant
6 grant
6 grant
6 grant
6 grant
6 idle 2
